/* rtl/periph_cfg.svh */
// Port bases, EMS windows and bus widths of the XT peripheral block
// I/O ports compare 16 address bits, memory cycles use all 20
// The EMS slot count must stay a power of two
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// Bus widths
`define PERIPH_ADDR_W 20
`define PERIPH_DATA_W 8

// Fixed I/O ports
`define PERIPH_EMS_PORT 16'h0260
`define PERIPH_LPT_PORT 16'h0378

// EMS page mapper
`define PERIPH_EMS_SLOTS 4

// Upper address nibble of each 64 KB window
`define PERIPH_EMS_WIN_A 4'b1010
`define PERIPH_EMS_WIN_C 4'b1100
`define PERIPH_EMS_WIN_D 4'b1101

// Parallel data latch after reset
`define PERIPH_LPT_RESET 8'hFF

`endif

/* rtl/periph_pkg.sv */
// Types shared by the peripheral block and its testbench
// All bus strobes are active low, all selects active high
`include "periph_cfg.svh"

package periph_pkg;

    // One ISA-style bus cycle as seen on a clock edge
    typedef struct packed {
        logic [`PERIPH_ADDR_W-1:0] address;
        logic [`PERIPH_DATA_W-1:0] write_data;
        logic                      io_read_n;
        logic                      io_write_n;
        logic                      memory_read_n;
        logic                      memory_write_n;
        logic                      address_enable_n;
    } isa_bus_t;

    typedef struct packed {
        logic dma;
        logic pic;
        logic pit;
        logic ppi;
        logic dma_page;
        logic ems;
        logic lpt;
        logic mem_cycle;
    } chip_sel_t;

    typedef struct packed {
        logic       enable;
        logic [6:0] page;
    } ems_slot_t;

    // Code 3 maps like D000
    typedef enum logic [1:0] {
        EMS_WIN_A000 = 2'd0,
        EMS_WIN_C000 = 2'd1,
        EMS_WIN_D000 = 2'd2
    } ems_window_e;

    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_EMS  = 2'd1,
        SRC_LPT  = 2'd2
    } readback_src_e;

endpackage

/* rtl/io_decoder.sv */
// Combinational port decode of the XT peripheral block
// Group selects use ten address bits, as on the XT board, so they alias
// Fixed ports (EMS, LPT) compare the full 16-bit port address
`timescale 1ns/1ps
`include "periph_cfg.svh"

module io_decoder import periph_pkg::*; (
    input  isa_bus_t  bus_i,
    input  logic      ems_enabled_i,
    output chip_sel_t sel_o
);

    logic io_request;
    logic io_cycle;
    logic low_ports;

    assign io_request = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign io_cycle   = io_request & ~bus_i.address_enable_n;
    assign low_ports  = bus_i.address[9:8] == 2'b00;

    always_comb begin
        sel_o = '0;

        // 32-port groups in the first 100h ports
        if (io_cycle && low_ports) begin
            case (bus_i.address[7:5])
                3'd0: sel_o.dma      = 1'b1;
                3'd1: sel_o.pic      = 1'b1;
                3'd2: sel_o.pit      = 1'b1;
                3'd3: sel_o.ppi      = 1'b1;
                3'd4: sel_o.dma_page = 1'b1;
                // Groups 5 to 7 belong to other cards
                default: begin
                end
            endcase
        end

        // 260h..263h
        sel_o.ems = io_cycle && ems_enabled_i
                    && ({bus_i.address[15:2], 2'b00} == `PERIPH_EMS_PORT);

        // 378h..37Fh
        sel_o.lpt = io_cycle
                    && ({bus_i.address[15:3], 3'b000} == `PERIPH_LPT_PORT);

        sel_o.mem_cycle = ~bus_i.address_enable_n & ~io_request;
    end

endmodule

/* rtl/ems_map_regs.sv */
// EMS slot registers at 260h..263h
// A write is sampled into a request register and lands in the slot one
// edge later; reads see it from the second edge after sampling
// Data 80h..FEh is ignored and leaves the slot as it was
`timescale 1ns/1ps
`include "periph_cfg.svh"

module ems_map_regs import periph_pkg::*; (
    input  logic                                clock,
    input  logic                                reset,
    input  isa_bus_t                            bus_i,
    input  logic                                ems_sel_i,
    output ems_slot_t [`PERIPH_EMS_SLOTS-1:0]   slots_o,
    output logic [`PERIPH_DATA_W-1:0]           ems_read_data_o
);

    localparam int SLOT_IDX_W = $clog2(`PERIPH_EMS_SLOTS);

    logic                  wr_unmap;
    logic                  wr_data_ok;
    logic                  wr_take;
    logic                  wr_req_valid;
    logic [SLOT_IDX_W-1:0] wr_req_index;
    ems_slot_t             wr_req_slot;
    ems_slot_t             rd_slot;

    assign wr_unmap   = bus_i.write_data == 8'hFF;
    assign wr_data_ok = wr_unmap || !bus_i.write_data[7];
    assign wr_take    = ems_sel_i && !bus_i.io_write_n && wr_data_ok;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_req_valid <= 1'b0;
        end else begin
            wr_req_valid <= wr_take;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_take) begin
            wr_req_index <= bus_i.address[SLOT_IDX_W-1:0];
            if (wr_unmap) begin
                wr_req_slot <= '{enable: 1'b0, page: 7'h7F};
            end else begin
                wr_req_slot <= '{enable: 1'b1, page: bus_i.write_data[6:0]};
            end
        end
    end

    // Slot update, second stage of the write
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            slots_o <= '0;
        end else if (wr_req_valid) begin
            slots_o[wr_req_index] <= wr_req_slot;
        end
    end

    assign rd_slot = slots_o[bus_i.address[SLOT_IDX_W-1:0]];

    // Unmapped slots read back as FFh
    assign ems_read_data_o = rd_slot.enable ? {1'b0, rd_slot.page} : 8'hFF;

    // A strobe held over several edges must keep its slot address
    a_index_stable: assert property (
        @(posedge clock) disable iff (reset)
        (wr_req_valid && $past(wr_req_valid)) |-> $stable(wr_req_index)
    );

endmodule

/* rtl/ems_window.sv */
// Bank selects for the four 16 KB EMS slots
// Only memory cycles hit; the window base comes from the window setting
`timescale 1ns/1ps
`include "periph_cfg.svh"

module ems_window import periph_pkg::*; (
    input  isa_bus_t                           bus_i,
    input  logic                               mem_cycle_i,
    input  ems_window_e                        window_i,
    input  ems_slot_t [`PERIPH_EMS_SLOTS-1:0]  slots_i,
    output logic [`PERIPH_EMS_SLOTS-1:0]       ems_bank_o
);

    localparam int SLOT_IDX_W = $clog2(`PERIPH_EMS_SLOTS);

    logic [3:0]            win_nibble;
    logic [SLOT_IDX_W+3:0] addr_top;

    assign addr_top = bus_i.address[`PERIPH_ADDR_W-1 -: SLOT_IDX_W + 4];

    always_comb begin
        case (window_i)
            EMS_WIN_A000: win_nibble = `PERIPH_EMS_WIN_A;
            EMS_WIN_C000: win_nibble = `PERIPH_EMS_WIN_C;
            default:      win_nibble = `PERIPH_EMS_WIN_D;
        endcase
    end

    // Slot k covers base + k * 16 KB
    always_comb begin
        for (int k = 0; k < `PERIPH_EMS_SLOTS; k++) begin
            ems_bank_o[k] = mem_cycle_i && slots_i[k].enable
                            && (addr_top == {win_nibble, SLOT_IDX_W'(k)});
        end
    end

endmodule

/* rtl/io_readback.sv */
// Parallel data latch and registered read-back for the EMS and LPT ports
// Read data shows one clock after the edge that sampled io_read_n low
// Outputs return to zero whenever no source is read
`timescale 1ns/1ps
`include "periph_cfg.svh"

module io_readback import periph_pkg::*; (
    input  logic                      clock,
    input  logic                      reset,
    input  isa_bus_t                  bus_i,
    input  chip_sel_t                 sel_i,
    input  logic [`PERIPH_DATA_W-1:0] ems_read_data_i,
    output logic [`PERIPH_DATA_W-1:0] data_bus_out_o,
    output logic                      data_bus_out_from_chipset_o
);

    logic [`PERIPH_DATA_W-1:0] lpt_data;
    readback_src_e             src;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_data <= `PERIPH_LPT_RESET;
        end else if (sel_i.lpt && !bus_i.io_write_n) begin
            lpt_data <= bus_i.write_data;
        end
    end

    // EMS wins over LPT
    always_comb begin
        if (bus_i.io_read_n) begin
            src = SRC_NONE;
        end else if (sel_i.ems) begin
            src = SRC_EMS;
        end else if (sel_i.lpt) begin
            src = SRC_LPT;
        end else begin
            src = SRC_NONE;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_bus_out_from_chipset_o <= 1'b0;
            data_bus_out_o              <= '0;
        end else begin
            data_bus_out_from_chipset_o <= src != SRC_NONE;
            case (src)
                SRC_EMS: data_bus_out_o <= ems_read_data_i;
                SRC_LPT: data_bus_out_o <= lpt_data;
                default: data_bus_out_o <= '0;
            endcase
        end
    end

    // The bus never strobes an I/O read and write together
    a_one_strobe: assert property (
        @(posedge clock) disable iff (reset)
        !(!bus_i.io_read_n && !bus_i.io_write_n)
    );

endmodule

/* rtl/periph_top.sv */
// XT peripheral block, I/O and memory side only
// Every input is sampled on the rising clock; the bus has no wait states
// Selects and bank outputs are combinational, read data is registered
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_top import periph_pkg::*; (
    input  logic                         clock,
    input  logic                         reset,
    input  isa_bus_t                     bus_i,
    input  logic                         ems_enabled_i,
    input  ems_window_e                  ems_window_i,
    output chip_sel_t                    chip_select_o,
    output logic [`PERIPH_EMS_SLOTS-1:0] ems_bank_o,
    output logic [`PERIPH_DATA_W-1:0]    data_bus_out_o,
    output logic                         data_bus_out_from_chipset_o
);

    chip_sel_t                          sel;
    ems_slot_t [`PERIPH_EMS_SLOTS-1:0]  slots;
    logic [`PERIPH_DATA_W-1:0]          ems_read_data;

    io_decoder u_io_decoder (
        .bus_i         (bus_i),
        .ems_enabled_i (ems_enabled_i),
        .sel_o         (sel)
    );

    ems_map_regs u_ems_map_regs (
        .clock           (clock),
        .reset           (reset),
        .bus_i           (bus_i),
        .ems_sel_i       (sel.ems),
        .slots_o         (slots),
        .ems_read_data_o (ems_read_data)
    );

    ems_window u_ems_window (
        .bus_i       (bus_i),
        .mem_cycle_i (sel.mem_cycle),
        .window_i    (ems_window_i),
        .slots_i     (slots),
        .ems_bank_o  (ems_bank_o)
    );

    io_readback u_io_readback (
        .clock                       (clock),
        .reset                       (reset),
        .bus_i                       (bus_i),
        .sel_i                       (sel),
        .ems_read_data_i             (ems_read_data),
        .data_bus_out_o              (data_bus_out_o),
        .data_bus_out_from_chipset_o (data_bus_out_from_chipset_o)
    );

    assign chip_select_o = sel;

endmodule

/* verification/periph_tb.sv */
// Directed testbench for periph_top
// Inputs change 1 ns after the rising clock. Registered read data is checked
// one clock after the edge that sampled the read strobe
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_tb import periph_pkg::*; ();

    localparam int MAX_CYCLES = 2000;
    // Strobes: io_read_n, io_write_n, memory_read_n, memory_write_n, address_enable_n
    localparam logic [4:0] STB_IDLE   = 5'b11111;
    localparam logic [4:0] STB_IO_RD  = 5'b01110;
    localparam logic [4:0] STB_IO_WR  = 5'b10110;
    localparam logic [4:0] STB_NO_AEN = 5'b01111;
    localparam logic [4:0] STB_MEM_RD = 5'b11010;

    logic        clock;
    logic        reset;
    isa_bus_t    bus_i;
    logic        ems_enabled_i;
    ems_window_e ems_window_i;
    chip_sel_t   chip_select_o;
    logic [3:0]  ems_bank_o;
    logic [7:0]  data_bus_out_o;
    logic        data_bus_out_from_chipset_o;

    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    integer      seed = 32'h5a34;
    // Expected slot contents
    logic        exp_en [4];
    logic [6:0]  exp_page [4];

    periph_top dut (.*);

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_sel(input string name, input chip_sel_t exp, input chip_sel_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bank(input string name, input logic [3:0] exp, input logic [3:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    function automatic isa_bus_t make_bus(input logic [19:0] addr, input logic [7:0] data,
                                          input logic [4:0] strobes);
        return isa_bus_t'({addr, data, strobes});
    endfunction

    task automatic drive_bus(input isa_bus_t bus);
        @(posedge clock);
        #1;
        bus_i = bus;
    endtask

    task automatic write_port(input logic [19:0] addr, input logic [7:0] data);
        drive_bus(make_bus(addr, data, STB_IO_WR));
        drive_bus(make_bus('0, '0, STB_IDLE));
    endtask

    // Read one port, then check both outputs after the sampling edge
    task automatic read_port(input logic [19:0] addr, input logic exp_flag,
                             input logic [7:0] exp_data);
        drive_bus(make_bus(addr, '0, STB_IO_RD));
        drive_bus(make_bus('0, '0, STB_IDLE));
        check_byte("data_bus_out_from_chipset_o", {7'b0, exp_flag},
                   {7'b0, data_bus_out_from_chipset_o});
        check_byte("data_bus_out_o", exp_data, data_bus_out_o);
    endtask

    function automatic chip_sel_t group_sel(input int group);
        chip_sel_t s;
        s = '0;
        case (group)
            0: s.dma = 1'b1;
            1: s.pic = 1'b1;
            2: s.pit = 1'b1;
            3: s.ppi = 1'b1;
            default: s.dma_page = 1'b1;
        endcase
        return s;
    endfunction

    function automatic logic [7:0] slot_value(input int k);
        return exp_en[k] ? {1'b0, exp_page[k]} : 8'hFF;
    endfunction

    // 64 KB window base for each setting
    function automatic logic [19:0] window_base(input ems_window_e w);
        case (w)
            EMS_WIN_A000: return 20'hA0000;
            EMS_WIN_C000: return 20'hC0000;
            default:      return 20'hD0000;
        endcase
    endfunction

    // FFh unmaps, below 80h maps, anything else is ignored
    task automatic ems_write(input int k, input logic [7:0] data);
        write_port(20'(`PERIPH_EMS_PORT + k), data);
        if (ems_enabled_i && data == 8'hFF) begin
            exp_en[k] = 1'b0;
            exp_page[k] = 7'h7F;
        end else if (ems_enabled_i && !data[7]) begin
            exp_en[k] = 1'b1;
            exp_page[k] = data[6:0];
        end
    endtask

    task automatic reset_values();
        logic [19:0] addr;
        check_byte("data_bus_out_from_chipset_o", 8'h00, {7'b0, data_bus_out_from_chipset_o});
        check_byte("data_bus_out_o", 8'h00, data_bus_out_o);
        // Memory cycles over the whole A000 window hit no slot
        for (int k = 0; k < 4; k++) begin
            addr = window_base(EMS_WIN_A000) + 20'(k * 20'h04000);
            drive_bus(make_bus(addr, 8'h00, STB_MEM_RD));
            #1;
            check_bank("ems_bank_o", 4'b0000, ems_bank_o);
        end
        read_port(20'(`PERIPH_LPT_PORT), 1'b1, 8'hFF);
    endtask

    task automatic port_decode();
        chip_sel_t exp;
        for (int g = 0; g < 5; g++) begin
            drive_bus(make_bus(20'(g * 32), 8'h00, STB_IO_RD));
            #1;
            check_sel("chip_select_o", group_sel(g), chip_select_o);
        end
        drive_bus(make_bus(20'h00020, 8'h00, STB_NO_AEN));
        #1;
        check_sel("chip_select_o", '0, chip_select_o);
        exp = '0;
        exp.ems = 1'b1;
        drive_bus(make_bus(20'h00262, 8'h00, STB_IO_RD));
        ems_enabled_i = 1'b1;
        #1;
        check_sel("chip_select_o", exp, chip_select_o);
        drive_bus(make_bus(20'h00262, 8'h00, STB_IO_RD));
        ems_enabled_i = 1'b0;
        #1;
        check_sel("chip_select_o", '0, chip_select_o);
        drive_bus(make_bus('0, '0, STB_IDLE));
    endtask

    task automatic ems_slots();
        ems_enabled_i = 1'b1;
        for (int k = 0; k < 4; k++) begin
            ems_write(k, {1'b0, 7'($random(seed))});
        end
        for (int k = 0; k < 4; k++) begin
            read_port(20'(`PERIPH_EMS_PORT + k), 1'b1, slot_value(k));
        end
        ems_write(1, 8'hFF);
        read_port(20'(`PERIPH_EMS_PORT + 1), 1'b1, 8'hFF);
        ems_write(2, 8'h90);
        read_port(20'(`PERIPH_EMS_PORT + 2), 1'b1, slot_value(2));
        ems_enabled_i = 1'b0;
        ems_write(0, {1'b0, ~exp_page[0]});
        ems_enabled_i = 1'b1;
        read_port(20'(`PERIPH_EMS_PORT), 1'b1, slot_value(0));
    endtask

    task automatic bank_select();
        logic [19:0] addr;
        for (int k = 0; k < 3; k++) begin
            ems_write(k, 8'(8'h10 + k));
        end
        ems_write(3, 8'hFF);
        for (int w = 0; w < 3; w++) begin
            for (int k = 0; k < 4; k++) begin
                addr = window_base(ems_window_e'(2'(w))) + 20'(k * 20'h04000) + 20'h01234;
                drive_bus(make_bus(addr, 8'h00, STB_MEM_RD));
                ems_window_i = ems_window_e'(2'(w));
                #1;
                check_bank("ems_bank_o", exp_en[k] ? 4'(1 << k) : 4'b0000, ems_bank_o);
                drive_bus(make_bus(addr, 8'h00, STB_IO_RD));
                #1;
                check_bank("ems_bank_o", 4'b0000, ems_bank_o);
            end
        end
    endtask

    task automatic parallel_latch();
        logic [7:0] data;
        // Bit 7 clear keeps it apart from the reset value
        data = {1'b0, 7'($random(seed))};
        write_port(20'(`PERIPH_LPT_PORT), data);
        read_port(20'(`PERIPH_LPT_PORT), 1'b1, data);
        read_port(20'h00300, 1'b0, 8'h00);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        bus_i = make_bus('0, '0, STB_IDLE);
        ems_enabled_i = 1'b0;
        ems_window_i = EMS_WIN_A000;
        for (int k = 0; k < 4; k++) begin
            exp_en[k] = 1'b0;
            exp_page[k] = 7'h00;
        end
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        reset_values();
        port_decode();
        ems_slots();
        bank_select();
        parallel_latch();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/periph_pkg.sv
rtl/io_decoder.sv
rtl/ems_map_regs.sv
rtl/ems_window.sv
rtl/io_readback.sv
rtl/periph_top.sv
verification/periph_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the peripheral testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module periph_tb -o periph_sim
./obj_dir/periph_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation passed"
